//--- hdl/pipeline_pkg.sv
package pipeline_pkg;

	typedef logic [15:0] instr_t;		// one instruction word
	typedef logic [2:0] reg_index_t;	// register number from a field
	typedef logic [2:0] cond_t;		// n, z, p
	typedef logic [1:0] op_class_t;	// bits 13:12
	typedef logic [1:0] addr_mode_t;	// bits 15:14
	typedef logic [4:0] enables_t;	// update pc, fetch, decode, execute, writeback

	// encoding is what the mem_state pins show
	typedef enum logic [1:0] {
		mem_read = 2'd0,
		mem_indirect = 2'd1,
		mem_write = 2'd2,
		mem_idle = 2'd3
	} mem_state_t;

	typedef enum logic [1:0] {
		pipe_reset,	// waiting for the first fetch
		pipe_start,	// first decode
		pipe_run
	} pipe_state_t;

	localparam instr_t nop_instr = '0;
	localparam logic [1:0] branch_resolve_count = 2'd2;	// br_taken cycle
	localparam logic [1:0] branch_resume_count = 2'd3;	// fetch from new pc

	localparam op_class_t class_control = 2'd0;	// br, jmp
	localparam op_class_t class_alu = 2'd1;
	localparam op_class_t class_load = 2'd2;
	localparam op_class_t class_store = 2'd3;

	localparam addr_mode_t mode_base = 2'd1;		// base + offset
	localparam addr_mode_t mode_indirect = 2'd2;	// two memory trips
	localparam addr_mode_t mode_effective = 2'd3;	// lea, or jmp in control class

	localparam int mode_lsb = 14;
	localparam int class_lsb = 12;
	localparam int dest_lsb = 9;		// also store source
	localparam int src1_lsb = 6;		// also base register
	localparam int imm_flag_bit = 5;
	localparam int src2_lsb = 0;

endpackage

//--- hdl/operand_bypass.sv
module operand_bypass import pipeline_pkg::*;
(
	input logic clock,
	input logic reset,
	input instr_t ir,			// instruction now in decode
	input logic stall,
	input logic pipeline_running,
	output logic bypass_alu_1,
	output logic bypass_alu_2,
	output logic bypass_mem_1,
	output logic bypass_mem_2
);

	instr_t prev_ir;			// producer, one stage ahead

	op_class_t cur_class;
	addr_mode_t cur_mode;
	op_class_t prev_class;
	addr_mode_t prev_mode;
	reg_index_t prev_dest;
	reg_index_t src1_index;
	reg_index_t src2_index;

	logic alu_producer;
	logic mem_producer;
	logic uses_src1;
	logic uses_src2;
	logic match_1;
	logic match_2;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			prev_ir <= nop_instr;
		end
		else if (!stall)
		begin
			prev_ir <= ir;		// frozen with the rest of the pipe
		end
	end

	// field split of both words
	assign cur_class = ir[class_lsb +: $bits(op_class_t)];
	assign cur_mode = ir[mode_lsb +: $bits(addr_mode_t)];
	assign prev_class = prev_ir[class_lsb +: $bits(op_class_t)];
	assign prev_mode = prev_ir[mode_lsb +: $bits(addr_mode_t)];
	assign prev_dest = prev_ir[dest_lsb +: $bits(reg_index_t)];

	// lea result comes off the alu path and other loads off memory
	assign alu_producer = (prev_class == class_alu) ||
		((prev_class == class_load) && (prev_mode == mode_effective));
	assign mem_producer = (prev_class == class_load) && (prev_mode != mode_effective);

	// source 1 is alu src1, jmp base or base-mode load/store base
	always_comb
	begin
		uses_src1 = 1'b0;
		case (cur_class)
			class_alu:
			begin
				uses_src1 = 1'b1;
			end
			class_control:
			begin
				uses_src1 = (cur_mode == mode_effective);	// jmp only
			end
			class_load, class_store:
			begin
				uses_src1 = (cur_mode == mode_base);
			end
		endcase
	end

	// source 2 is the alu register operand or the store data register
	assign uses_src2 = ((cur_class == class_alu) && !ir[imm_flag_bit]) ||
		((cur_class == class_store) && (cur_mode == mode_base));
	assign src1_index = ir[src1_lsb +: $bits(reg_index_t)];
	assign src2_index = (cur_class == class_alu) ? ir[src2_lsb +: $bits(reg_index_t)]
		: ir[dest_lsb +: $bits(reg_index_t)];	// store source sits in dest field

	assign match_1 = pipeline_running && uses_src1 && (src1_index == prev_dest);
	assign match_2 = pipeline_running && uses_src2 && (src2_index == prev_dest);

	assign bypass_alu_1 = match_1 && alu_producer;
	assign bypass_alu_2 = match_2 && alu_producer;
	assign bypass_mem_1 = match_1 && mem_producer;
	assign bypass_mem_2 = match_2 && mem_producer;

endmodule

//--- hdl/fetch_sequencer.sv
module fetch_sequencer import pipeline_pkg::*;
(
	input logic clock,
	input logic reset,
	input instr_t instr_dout,		// word coming back from instruction memory
	input logic complete_instr,
	input instr_t ir,
	input cond_t psr,
	input cond_t nzp,			// branch mask
	input logic stall,
	input logic store_done,
	output logic enable_update_pc,
	output logic enable_fetch,
	output logic enable_decode,
	output logic enable_execute,
	output logic enable_writeback,
	output logic br_taken,
	output logic pipeline_running
);

	pipe_state_t state;
	pipe_state_t next_state;
	enables_t enables;			// before writeback and stall gating
	enables_t prev_enables;
	enables_t gated_enables;
	logic [1:0] bubble_count;
	logic count_inc;
	logic count_clear;
	logic control_fetch;
	logic branch_active;
	logic branch_hit;
	logic advance;
	logic writeback_block;

	// nonzero control word out of imem means br or jmp
	assign control_fetch = (instr_dout[class_lsb +: $bits(op_class_t)] == class_control) &&
		(instr_dout != nop_instr);
	assign branch_active = (bubble_count != 2'd0);
	assign branch_hit = |(psr & nzp);
	assign advance = (complete_instr || branch_active) && !stall;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= pipe_reset;
			prev_enables <= '0;
		end
		else if (!stall)
		begin
			state <= next_state;
			prev_enables <= enables;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			bubble_count <= 2'd0;
		end
		else if (!stall)
		begin
			if (count_clear)
			begin
				bubble_count <= 2'd0;	// branch over and back to normal fetch
			end
			else if (count_inc)
			begin
				bubble_count <= bubble_count + 2'd1;
			end
		end
	end

	always_comb
	begin
		next_state = state;
		enables = '0;
		br_taken = 1'b0;
		count_inc = 1'b0;
		count_clear = 1'b0;
		case (state)
			pipe_reset:
			begin
				if (complete_instr)
				begin
					enables = 5'b11000;	// first word in so the pc moves
					next_state = pipe_start;
				end
				else
				begin
					enables = 5'b01000;	// keep fetching the reset pc
				end
			end
			pipe_start:
			begin
				next_state = pipe_run;
				if (!complete_instr)
				begin
					enables = 5'b01100;
				end
				else if (control_fetch)
				begin
					enables = 5'b00100;	// branch at the reset pc
					count_inc = 1'b1;
				end
				else
				begin
					enables = 5'b11100;
				end
			end
			pipe_run:
			begin
				// back end follows the previous enables and a nop kills execute
				if (ir == nop_instr)
				begin
					enables[1:0] = {1'b0, prev_enables[1]};
				end
				else
				begin
					enables[1:0] = prev_enables[2:1];
				end
				if (!advance)
				begin
					enables[4:2] = 3'b010;	// wait on imem
				end
				else if (branch_active || control_fetch)
				begin
					count_inc = 1'b1;
					if (bubble_count == branch_resolve_count)
					begin
						br_taken = branch_hit;
						enables[4:2] = {branch_hit, 1'b0, prev_enables[3]};
					end
					else if (bubble_count == branch_resume_count)
					begin
						count_inc = 1'b0;
						count_clear = 1'b1;
						enables[4:2] = {1'b1, 1'b1, prev_enables[3]};	// fetch target
					end
					else
					begin
						enables[4:2] = {1'b0, 1'b0, prev_enables[3]};	// bubble
					end
				end
				else
				begin
					enables[4:2] = {1'b1, 1'b1, prev_enables[3]};
				end
			end
			default:
			begin
				next_state = pipe_reset;
			end
		endcase
	end

	// no register write for a finished store or a resolving branch
	assign writeback_block = store_done || (bubble_count == branch_resolve_count);
	assign gated_enables = {enables[4:1], enables[0] && !writeback_block};
	assign {enable_update_pc, enable_fetch, enable_decode, enable_execute, enable_writeback} =
		stall ? '0 : gated_enables;
	assign pipeline_running = (state == pipe_run);

endmodule

//--- hdl/memory_access_control.sv
module memory_access_control import pipeline_pkg::*;
(
	input logic clock,
	input logic reset,
	input instr_t ir_exec,		// instruction leaving execute
	input logic complete_data,	// dmem done strobe
	output logic stall,
	output logic store_done,
	output mem_state_t mem_state
);

	mem_state_t state;
	mem_state_t next_state;
	op_class_t exec_class;
	addr_mode_t exec_mode;
	logic is_store;
	logic needs_memory;

	assign exec_class = ir_exec[class_lsb +: $bits(op_class_t)];
	assign exec_mode = ir_exec[mode_lsb +: $bits(addr_mode_t)];
	assign is_store = (exec_class == class_store);
	// lea is load class but never touches memory
	assign needs_memory = ((exec_class == class_load) || is_store) &&
		(exec_mode != mode_effective);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= mem_idle;
		end
		else
		begin
			state <= next_state;	// runs through stall
		end
	end

	always_comb
	begin
		next_state = state;
		stall = 1'b0;
		case (state)
			mem_idle:
			begin
				if (needs_memory)
				begin
					stall = 1'b1;	// freeze the pipe this cycle
					if (exec_mode == mode_indirect)
					begin
						next_state = mem_indirect;	// fetch the pointer first
					end
					else if (is_store)
					begin
						next_state = mem_write;
					end
					else
					begin
						next_state = mem_read;
					end
				end
			end
			mem_indirect:
			begin
				stall = 1'b1;		// pointer arriving is not the end
				if (complete_data)
				begin
					next_state = is_store ? mem_write : mem_read;
				end
			end
			mem_read, mem_write:
			begin
				if (complete_data)
				begin
					next_state = mem_idle;	// release in the same cycle
				end
				else
				begin
					stall = 1'b1;
				end
			end
		endcase
	end

	assign store_done = complete_data && (state == mem_write);
	assign mem_state = next_state;	// pins show where we are heading

endmodule

//--- hdl/pipeline_controller.sv
module pipeline_controller import pipeline_pkg::*;
(
	input logic clock,
	input logic reset,
	input instr_t ir,			// decode stage instruction
	input instr_t ir_exec,		// execute stage instruction
	input instr_t instr_dout,		// imem read data
	input cond_t psr,
	input cond_t nzp,
	input logic complete_instr,
	input logic complete_data,
	output logic bypass_alu_1,
	output logic bypass_alu_2,
	output logic bypass_mem_1,
	output logic bypass_mem_2,
	output logic enable_update_pc,
	output logic enable_fetch,
	output logic enable_decode,
	output logic enable_execute,
	output logic enable_writeback,
	output logic br_taken,
	output mem_state_t mem_state
);

	logic stall;			// whole-pipe freeze from dmem
	logic store_done;
	logic pipeline_running;

	memory_access_control u_memory_access_control (
		.clock(clock),
		.reset(reset),
		.ir_exec(ir_exec),
		.complete_data(complete_data),
		.stall(stall),
		.store_done(store_done),
		.mem_state(mem_state)
	);

	fetch_sequencer u_fetch_sequencer (
		.clock(clock),
		.reset(reset),
		.instr_dout(instr_dout),
		.complete_instr(complete_instr),
		.ir(ir),
		.psr(psr),
		.nzp(nzp),
		.stall(stall),
		.store_done(store_done),
		.enable_update_pc(enable_update_pc),
		.enable_fetch(enable_fetch),
		.enable_decode(enable_decode),
		.enable_execute(enable_execute),
		.enable_writeback(enable_writeback),
		.br_taken(br_taken),
		.pipeline_running(pipeline_running)
	);

	operand_bypass u_operand_bypass (
		.clock(clock),
		.reset(reset),
		.ir(ir),
		.stall(stall),
		.pipeline_running(pipeline_running),
		.bypass_alu_1(bypass_alu_1),
		.bypass_alu_2(bypass_alu_2),
		.bypass_mem_1(bypass_mem_1),
		.bypass_mem_2(bypass_mem_2)
	);

endmodule

//--- testbench/pipeline_controller_properties.sv
module pipeline_controller_properties
(
	input logic clock,
	input logic reset,
	input logic stall,				// internal dmem freeze
	input logic enable_update_pc,
	input logic enable_fetch,
	input logic enable_decode,
	input logic enable_execute,
	input logic enable_writeback,
	input logic br_taken
);
	timeunit 1ns;
	timeprecision 1ps;

	int assert_failures = 0;

	// frozen pipe moves nothing
	stall_blocks_enables: assert property (@(posedge clock) disable iff (reset)
		stall |-> !(enable_update_pc || enable_fetch || enable_decode || enable_execute ||
		enable_writeback))
	else
	begin
		assert_failures++;
		$error("stage enable high while stall is high");
	end

	// taken branch redirects the pc so nothing comes from the old one
	branch_blocks_fetch: assert property (@(posedge clock) disable iff (reset)
		!(br_taken && enable_fetch))
	else
	begin
		assert_failures++;
		$error("br_taken and enable_fetch high together");
	end

endmodule

//--- testbench/pipeline_checker.sv
module pipeline_checker import pipeline_pkg::*;
(
	input logic clock,
	input logic vector_valid,
	input logic vectors_done,
	input logic [7:0] test_num,
	input enables_t exp_enables,		// upc, fetch, decode, execute, writeback
	input logic exp_br_taken,
	input logic [3:0] exp_bypass,		// alu1, alu2, mem1, mem2
	input logic [1:0] exp_mem_state,
	input logic bypass_alu_1,
	input logic bypass_alu_2,
	input logic bypass_mem_1,
	input logic bypass_mem_2,
	input logic enable_update_pc,
	input logic enable_fetch,
	input logic enable_decode,
	input logic enable_execute,
	input logic enable_writeback,
	input logic br_taken,
	input mem_state_t mem_state,
	output int check_count,
	output int error_count,
	output logic summary_ready
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [7:0] current_test;
	logic test_active;
	int test_cycles;
	int test_errors;
	int test_count;

	initial
	begin
		check_count = 0;
		error_count = 0;
		summary_ready = 1'b0;
		test_active = 1'b0;
		test_count = 0;
	end

	task automatic check_value(input string name, input logic [4:0] expected,
		input logic [4:0] actual);
		begin
			check_count++;
			if (actual !== expected)
			begin
				error_count++;
				test_errors++;
				$display("FAILED test %0d cycle %0d %s expected %h actual %h", current_test,
					test_cycles, name, expected, actual);
			end
		end
	endtask

	task automatic close_test();
		begin
			$display("test %0d finished: %0d cycles, %0d errors", current_test, test_cycles,
				test_errors);
			test_count++;
			test_active = 1'b0;
		end
	endtask

	// mid-cycle sample of inputs driven 2 ns after the edge
	always @(negedge clock)
	begin
		if (vector_valid)
		begin
			if (test_active && test_num != current_test)
			begin
				close_test();
			end
			if (!test_active)
			begin
				current_test = test_num;
				test_active = 1'b1;
				test_cycles = 0;
				test_errors = 0;
			end
			test_cycles++;
			check_value("enable_update_pc", 5'(exp_enables[4]), 5'(enable_update_pc));
			check_value("enable_fetch", 5'(exp_enables[3]), 5'(enable_fetch));
			check_value("enable_decode", 5'(exp_enables[2]), 5'(enable_decode));
			check_value("enable_execute", 5'(exp_enables[1]), 5'(enable_execute));
			check_value("enable_writeback", 5'(exp_enables[0]), 5'(enable_writeback));
			check_value("br_taken", 5'(exp_br_taken), 5'(br_taken));
			check_value("bypass_alu_1", 5'(exp_bypass[3]), 5'(bypass_alu_1));
			check_value("bypass_alu_2", 5'(exp_bypass[2]), 5'(bypass_alu_2));
			check_value("bypass_mem_1", 5'(exp_bypass[1]), 5'(bypass_mem_1));
			check_value("bypass_mem_2", 5'(exp_bypass[0]), 5'(bypass_mem_2));
			check_value("mem_state", 5'(exp_mem_state), 5'(mem_state));
		end
		else if (vectors_done && !summary_ready)
		begin
			if (test_active)
			begin
				close_test();
			end
			$display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
			summary_ready = 1'b1;
		end
	end

endmodule

//--- testbench/tb_pipeline_controller.sv
module tb_pipeline_controller
	import pipeline_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam string vector_path = "testbench/pipeline_vectors.txt";
	localparam int max_lines = 1000;		// bound on the vector read loop
	localparam int summary_timeout = 20;	// cycles

	logic clock;
	logic reset;
	instr_t ir;
	instr_t ir_exec;
	instr_t instr_dout;
	cond_t psr;
	cond_t nzp;
	logic complete_instr;
	logic complete_data;
	logic bypass_alu_1;
	logic bypass_alu_2;
	logic bypass_mem_1;
	logic bypass_mem_2;
	logic enable_update_pc;
	logic enable_fetch;
	logic enable_decode;
	logic enable_execute;
	logic enable_writeback;
	logic br_taken;
	mem_state_t mem_state;

	logic [7:0] test_num;		// expected record for the checker
	enables_t exp_enables;
	logic exp_br_taken;
	logic [3:0] exp_bypass;
	logic [1:0] exp_mem_state;
	logic vector_valid;
	logic vectors_done;
	int check_count;
	int error_count;
	logic summary_ready;

	pipeline_controller i_pipeline_controller (.*);

	pipeline_checker u_checker (.*);

	bind pipeline_controller pipeline_controller_properties u_properties (.*);

	initial
	begin
		clock = 1'b0;
		forever #10 clock = ~clock;		// 20 ns period
	end

	initial
	begin
		int fd;
		int line_no;
		int fields;
		int wait_cycles;
		int format_errors;
		int assert_failures;
		string line;
		logic [7:0] t_test;
		logic [15:0] t_ir;
		logic [15:0] t_ir_exec;
		logic [15:0] t_dout;
		logic [2:0] t_psr;
		logic [2:0] t_nzp;
		logic t_ci;
		logic t_cd;
		logic [4:0] t_en;
		logic t_br;
		logic [3:0] t_byp;
		logic [1:0] t_mem;
		reset = 1'b1;
		ir = nop_instr;
		ir_exec = nop_instr;
		instr_dout = nop_instr;
		psr = '0;
		nzp = '0;
		complete_instr = 1'b0;
		complete_data = 1'b0;
		test_num = '0;
		exp_enables = '0;
		exp_br_taken = 1'b0;
		exp_bypass = '0;
		exp_mem_state = '0;
		vector_valid = 1'b0;
		vectors_done = 1'b0;
		format_errors = 0;
		line_no = 0;
		fd = $fopen(vector_path, "r");
		if (fd == 0)
		begin
			$display("could not open %s", vector_path);
			format_errors++;
		end
		repeat (2) @(posedge clock);	// reset held two cycles
		while (fd != 0 && !$feof(fd) && line_no < max_lines)
		begin
			line = "";
			void'($fgets(line, fd));
			line_no++;
			if (line.len() > 1 && line.getc(0) != "#")		// skip blanks and notes
			begin
				fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", t_test, t_ir,
					t_ir_exec, t_dout, t_psr, t_nzp, t_ci, t_cd, t_en, t_br, t_byp, t_mem);
				if (fields != 12)
				begin
					$display("vector file line %0d has %0d fields, not 12", line_no, fields);
					format_errors++;
				end
				else
				begin
					#2;		// drive just after the edge
					reset = 1'b0;
					ir = t_ir;
					ir_exec = t_ir_exec;
					instr_dout = t_dout;
					psr = t_psr;
					nzp = t_nzp;
					complete_instr = t_ci;
					complete_data = t_cd;
					test_num = t_test;
					exp_enables = t_en;
					exp_br_taken = t_br;
					exp_bypass = t_byp;
					exp_mem_state = t_mem;
					vector_valid = 1'b1;
					@(posedge clock);
				end
			end
		end
		if (fd != 0 && !$feof(fd))
		begin
			$display("vector file is longer than %0d lines", max_lines);
			format_errors++;
		end
		if (fd != 0)
		begin
			$fclose(fd);
		end
		#2;
		vector_valid = 1'b0;
		vectors_done = 1'b1;		// checker closes the last test
		wait_cycles = 0;
		while (!summary_ready && wait_cycles < summary_timeout)
		begin
			@(posedge clock);
			wait_cycles++;
		end
		assert_failures = i_pipeline_controller.u_properties.assert_failures;
		if (!summary_ready)
		begin
			$display("checker gave no summary within %0d cycles", summary_timeout);
		end
		if (assert_failures != 0)
		begin
			$display("%0d assertion failures on stall or branch behavior", assert_failures);
		end
		if (summary_ready && error_count == 0 && check_count > 0 && format_errors == 0 &&
			assert_failures == 0)
		begin
			$display("Simulation finished: PASS");
		end
		else
		begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- testbench/pipeline_vectors.txt
# test ir ir_exec instr_dout psr nzp complete_instr complete_data, then expected:
# enables(upc fetch decode execute writeback) br_taken bypass(alu1 alu2 mem1 mem2) mem_state
1 0000 0000 0000 0 0 0 0 08 0 0 3
1 0000 0000 0000 0 0 0 0 08 0 0 3
2 0000 0000 1642 0 0 1 0 18 0 0 3
2 1642 0000 1642 0 0 1 0 1c 0 0 3
2 18c3 0000 1642 0 0 1 0 1e 0 c 3
2 6a80 0000 1642 0 0 1 0 1f 0 0 3
2 7b40 0000 1642 0 0 1 0 1f 0 3 3
2 ec00 0000 1642 0 0 1 0 1f 0 0 3
2 c180 0000 1642 0 0 1 0 1f 0 8 3
3 1642 a200 1642 0 0 1 0 00 0 0 1
3 1642 a200 1642 0 0 1 0 00 0 0 1
3 1642 a200 1642 0 0 1 1 00 0 0 0
3 1642 a200 1642 0 0 1 0 00 0 0 0
3 1642 a200 1642 0 0 1 1 1f 0 0 3
4 1642 0000 0e05 2 3 1 0 07 0 0 3
4 1642 0000 0000 2 3 0 0 03 0 0 3
4 1642 0000 0000 2 3 0 0 10 1 0 3
4 1642 0000 0000 2 3 0 0 18 0 0 3
4 1642 0000 1642 2 3 1 0 1c 0 0 3
5 1642 0000 0e05 4 3 1 0 06 0 0 3
5 1642 0000 0000 4 3 0 0 03 0 0 3
5 1642 0000 0000 4 3 0 0 00 0 0 3
5 1642 0000 0000 4 3 0 0 18 0 0 3
5 1642 0000 1642 4 3 1 0 1c 0 0 3
5 1642 0000 1642 4 3 1 0 1e 0 0 3
5 1642 0000 1642 4 3 1 0 1f 0 0 3
5 0000 0000 1642 4 3 1 0 1d 0 0 3
5 1642 0000 1642 4 3 1 0 1e 0 0 3
5 1642 3400 1642 4 3 1 0 00 0 0 2
5 1642 3400 1642 4 3 1 1 1e 0 0 3
5 1642 0000 1642 4 3 1 0 1f 0 0 3

//--- all.f
hdl/pipeline_pkg.sv
hdl/operand_bypass.sv
hdl/fetch_sequencer.sv
hdl/memory_access_control.sv
hdl/pipeline_controller.sv
testbench/pipeline_controller_properties.sv
testbench/pipeline_checker.sv
testbench/tb_pipeline_controller.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_pipeline_controller
FILE_LIST ?= all.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS ?= --binary --timing --assert -j 0
RUN_ARGS ?= +verilator+error+limit+100
PASS_TEXT = Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only -Wall --timing --timescale $(TIMESCALE) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR)
